// File: include/fpu_int_macros.svh
`ifndef FPU_INT_MACROS_SVH
`define FPU_INT_MACROS_SVH

// Exponent field width of binary32
`define FPU_EXP_WIDTH 8

// Significand width, hidden bit included
`define FPU_SIG_WIDTH 24

// Integer register width, also the width of a raw operand
`define FPU_DATA_WIDTH 32

`endif

// File: hw/fpu_int_pkg.sv
`default_nettype none

`include "fpu_int_macros.svh"

package fpu_int_pkg;

  // Operations that write back to the integer register file
  typedef enum logic [2:0] {
    eFEQ,
    eFLT,
    eFLE,
    eFCVT_W_S,
    eFCVT_WU_S,
    eFCLASS,
    eFMV_X_W
  } fpu_int_op_e;

  // RISC-V frm encodings
  typedef enum logic [2:0] {
    eRNE = 3'd0,
    eRTZ = 3'd1,
    eRDN = 3'd2,
    eRUP = 3'd3,
    eRMM = 3'd4
  } frm_e;

  // Same bit order as fflags in fcsr
  typedef struct packed {
    logic invalid;
    logic div_zero;
    logic overflow;
    logic underflow;
    logic inexact;
  } fflags_s;

  typedef struct packed {
    fpu_int_op_e                op;
    frm_e                       rm;
    logic [`FPU_DATA_WIDTH-1:0] rs1;
    logic [`FPU_DATA_WIDTH-1:0] rs2;
  } fpu_int_req_s;

  typedef struct packed {
    logic [`FPU_DATA_WIDTH-1:0] result;
    fflags_s                    fflags;
  } fpu_int_resp_s;

endpackage

`default_nettype wire

// File: hw/fpu_int_compare.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_int_macros.svh"

module fpu_int_compare
  import fpu_int_pkg::*;
  #(parameter exp_width_p = `FPU_EXP_WIDTH
    , parameter sig_width_p = `FPU_SIG_WIDTH
  )
  (
    input  logic [exp_width_p+sig_width_p-1:0] a_i
    , input  logic [exp_width_p+sig_width_p-1:0] b_i
    , input  logic                             signaling_i
    , output logic                             lt_o
    , output logic                             eq_o
    , output logic                             unordered_o
    , output fflags_s                          fflags_o
  );

  localparam int fp_width_lp = exp_width_p + sig_width_p;

  logic                         a_sign, b_sign;
  logic [exp_width_p-1:0]       a_exp, b_exp;
  logic [sig_width_p-2:0]       a_frac, b_frac;
  logic [fp_width_lp-2:0]       a_mag, b_mag;
  logic                         a_nan, b_nan;
  logic                         a_snan, b_snan;
  logic                         both_zero;
  logic                         lt_raw;

  assign a_sign = a_i[fp_width_lp-1];
  assign b_sign = b_i[fp_width_lp-1];
  assign a_exp  = a_i[fp_width_lp-2 -: exp_width_p];
  assign b_exp  = b_i[fp_width_lp-2 -: exp_width_p];
  assign a_frac = a_i[sig_width_p-2:0];
  assign b_frac = b_i[sig_width_p-2:0];

  // Exponent and fraction together order like an unsigned magnitude
  assign a_mag = a_i[fp_width_lp-2:0];
  assign b_mag = b_i[fp_width_lp-2:0];

  assign a_nan  = (&a_exp) & (|a_frac);
  assign b_nan  = (&b_exp) & (|b_frac);
  // Quiet bit is the top fraction bit
  assign a_snan = a_nan & ~a_frac[sig_width_p-2];
  assign b_snan = b_nan & ~b_frac[sig_width_p-2];

  assign unordered_o = a_nan | b_nan;

  // +0 and -0 are the same value
  assign both_zero = (a_mag == '0) && (b_mag == '0);

  always_comb begin
    if (both_zero) begin
      lt_raw = 1'b0;
    end else if (a_sign != b_sign) begin
      lt_raw = a_sign;
    end else if (a_sign) begin
      // Both negative, larger magnitude is smaller
      lt_raw = a_mag > b_mag;
    end else begin
      lt_raw = a_mag < b_mag;
    end
  end

  assign lt_o = ~unordered_o & lt_raw;
  assign eq_o = ~unordered_o & ((a_i == b_i) | both_zero);

  always_comb begin
    fflags_o           = '0;
    fflags_o.invalid   = signaling_i ? unordered_o : (a_snan | b_snan);
  end

endmodule

`default_nettype wire

// File: hw/fpu_int_f2i.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_int_macros.svh"

module fpu_int_f2i
  import fpu_int_pkg::*;
  #(parameter exp_width_p = `FPU_EXP_WIDTH
    , parameter sig_width_p = `FPU_SIG_WIDTH
    , parameter data_width_p = `FPU_DATA_WIDTH
  )
  (
    input  logic [exp_width_p+sig_width_p-1:0] a_i
    , input  frm_e                             rm_i
    , input  logic                             signed_i
    , output logic [data_width_p-1:0]          result_o
    , output fflags_s                          fflags_o
  );

  localparam int fp_width_lp    = exp_width_p + sig_width_p;
  localparam int bias_lp        = (1 << (exp_width_p-1)) - 1;
  // Fixed point with data_width_p integer bits and sig_width_p fraction bits
  localparam int fix_width_lp   = data_width_p + sig_width_p;
  localparam int shift_width_lp = $clog2(fix_width_lp + 1);

  localparam logic [data_width_p:0] pos_lim_lp = {2'b00, {(data_width_p-1){1'b1}}};
  localparam logic [data_width_p:0] neg_lim_lp = {2'b01, {(data_width_p-1){1'b0}}};

  logic                          sign;
  logic [exp_width_p-1:0]        exp_field;
  logic [exp_width_p-1:0]        exp_eff;
  logic [sig_width_p-2:0]        frac;
  logic [sig_width_p-1:0]        sig;
  logic                          is_nan, is_inf;
  logic signed [exp_width_p+1:0] exp_unb;
  logic [exp_width_p+1:0]        neg_exp;
  logic                          too_big;
  logic [shift_width_lp-1:0]     lsh, rsh;
  logic [fix_width_lp-1:0]       base;
  logic [2*fix_width_lp-1:0]     wide;
  logic [fix_width_lp-1:0]       fix;
  logic [data_width_p-1:0]       int_part;
  logic                          guard, sticky, inexact_raw;
  logic                          round_up;
  logic [data_width_p:0]         rounded;
  logic                          out_of_range, invalid;

  assign sign      = a_i[fp_width_lp-1];
  assign exp_field = a_i[fp_width_lp-2 -: exp_width_p];
  assign frac      = a_i[sig_width_p-2:0];

  assign is_nan = (&exp_field) & (|frac);
  assign is_inf = (&exp_field) & ~(|frac);

  // Subnormals use the minimum exponent with no hidden bit
  assign exp_eff = (exp_field == '0) ? exp_width_p'(1) : exp_field;
  assign sig     = {|exp_field, frac};
  assign exp_unb = $signed({2'b00, exp_eff}) - $signed((exp_width_p+2)'(bias_lp));
  assign neg_exp = -exp_unb;
  assign too_big = exp_unb >= $signed((exp_width_p+2)'(data_width_p));

  assign lsh = exp_unb[shift_width_lp-1:0];
  assign rsh = (neg_exp > fix_width_lp) ? shift_width_lp'(fix_width_lp)
                                        : neg_exp[shift_width_lp-1:0];

  // 1.fff with sig_width_p fraction bits
  assign base = {{(data_width_p-1){1'b0}}, sig, 1'b0};

  always_comb begin
    if (exp_unb < 0) begin
      wide = {base, {fix_width_lp{1'b0}}} >> rsh;
    end else if (too_big) begin
      wide = '0;
    end else begin
      wide = {base << lsh, {fix_width_lp{1'b0}}};
    end
  end

  assign fix         = wide[2*fix_width_lp-1:fix_width_lp];
  assign int_part    = fix[fix_width_lp-1:sig_width_p];
  assign guard       = fix[sig_width_p-1];
  assign sticky      = (|fix[sig_width_p-2:0]) | (|wide[fix_width_lp-1:0]);
  assign inexact_raw = guard | sticky;

  always_comb begin
    case (rm_i)
      eRTZ: round_up = 1'b0;
      eRDN: round_up = sign & inexact_raw;
      eRUP: round_up = ~sign & inexact_raw;
      eRMM: round_up = guard;
      // RNE, also for reserved encodings
      default: round_up = guard & (sticky | int_part[0]);
    endcase
  end

  assign rounded = {1'b0, int_part} + (data_width_p+1)'(round_up);

  always_comb begin
    if (signed_i) begin
      out_of_range = sign ? (rounded > neg_lim_lp) : (rounded > pos_lim_lp);
    end else begin
      // Any negative value that survives rounding is invalid
      out_of_range = sign ? (rounded != '0) : rounded[data_width_p];
    end
  end

  assign invalid = is_nan | is_inf | too_big | out_of_range;

  always_comb begin
    if (invalid) begin
      if (is_nan || !sign) begin
        result_o = signed_i ? pos_lim_lp[data_width_p-1:0] : {data_width_p{1'b1}};
      end else begin
        result_o = signed_i ? neg_lim_lp[data_width_p-1:0] : '0;
      end
    end else begin
      result_o = sign ? -rounded[data_width_p-1:0] : rounded[data_width_p-1:0];
    end
  end

  always_comb begin
    fflags_o         = '0;
    fflags_o.invalid = invalid;
    fflags_o.inexact = ~invalid & inexact_raw;
  end

endmodule

`default_nettype wire

// File: hw/fpu_int_fclass.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_int_macros.svh"

module fpu_int_fclass
  #(parameter exp_width_p = `FPU_EXP_WIDTH
    , parameter sig_width_p = `FPU_SIG_WIDTH
  )
  (
    input  logic [exp_width_p+sig_width_p-1:0] a_i
    , output logic [9:0]                       class_o
  );

  localparam int fp_width_lp = exp_width_p + sig_width_p;

  logic                   sign;
  logic [exp_width_p-1:0] exp_field;
  logic [sig_width_p-2:0] frac;
  logic                   exp_ones, exp_zero, frac_zero;
  logic                   is_inf, is_nan, is_zero, is_sub, is_norm;

  assign sign      = a_i[fp_width_lp-1];
  assign exp_field = a_i[fp_width_lp-2 -: exp_width_p];
  assign frac      = a_i[sig_width_p-2:0];

  assign exp_ones  = &exp_field;
  assign exp_zero  = ~(|exp_field);
  assign frac_zero = ~(|frac);

  assign is_inf  = exp_ones & frac_zero;
  assign is_nan  = exp_ones & ~frac_zero;
  assign is_zero = exp_zero & frac_zero;
  assign is_sub  = exp_zero & ~frac_zero;
  assign is_norm = ~exp_ones & ~exp_zero;

  // One-hot, negative classes in the low bits
  assign class_o[0] = sign & is_inf;
  assign class_o[1] = sign & is_norm;
  assign class_o[2] = sign & is_sub;
  assign class_o[3] = sign & is_zero;
  assign class_o[4] = ~sign & is_zero;
  assign class_o[5] = ~sign & is_sub;
  assign class_o[6] = ~sign & is_norm;
  assign class_o[7] = ~sign & is_inf;
  // NaN classes ignore the sign, quiet bit decides
  assign class_o[8] = is_nan & ~frac[sig_width_p-2];
  assign class_o[9] = is_nan & frac[sig_width_p-2];

endmodule

`default_nettype wire

// File: hw/fpu_int.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_int_macros.svh"

module fpu_int
  import fpu_int_pkg::*;
  #(parameter exp_width_p = `FPU_EXP_WIDTH
    , parameter sig_width_p = `FPU_SIG_WIDTH
    , parameter data_width_p = `FPU_DATA_WIDTH
  )
  (
    input  fpu_int_op_e                 op_i
    , input  frm_e                      rm_i
    , input  logic [data_width_p-1:0]   rs1_i
    , input  logic [data_width_p-1:0]   rs2_i
    , output logic [data_width_p-1:0]   result_o
    , output fflags_s                   fflags_o
  );

  logic is_feq, is_flt, is_fle;
  logic is_cmp, is_cvt;

  assign is_feq = op_i == eFEQ;
  assign is_flt = op_i == eFLT;
  assign is_fle = op_i == eFLE;
  assign is_cmp = is_feq | is_flt | is_fle;
  assign is_cvt = (op_i == eFCVT_W_S) | (op_i == eFCVT_WU_S);

  // FLT and FLE signal on any NaN, FEQ only on sNaN
  logic    cmp_lt, cmp_eq;
  logic    cmp_bit;
  fflags_s cmp_fflags;

  fpu_int_compare #(
    .exp_width_p(exp_width_p)
    ,.sig_width_p(sig_width_p)
  ) cmp0 (
    .a_i(rs1_i)
    ,.b_i(rs2_i)
    ,.signaling_i(is_flt | is_fle)
    ,.lt_o(cmp_lt)
    ,.eq_o(cmp_eq)
    ,.unordered_o()
    ,.fflags_o(cmp_fflags)
  );

  // lt and eq already read low on a NaN
  always_comb begin
    if (is_flt) begin
      cmp_bit = cmp_lt;
    end else if (is_fle) begin
      cmp_bit = cmp_lt | cmp_eq;
    end else begin
      cmp_bit = cmp_eq;
    end
  end

  logic [data_width_p-1:0] f2i_result;
  fflags_s                 f2i_fflags;

  fpu_int_f2i #(
    .exp_width_p(exp_width_p)
    ,.sig_width_p(sig_width_p)
    ,.data_width_p(data_width_p)
  ) f2i0 (
    .a_i(rs1_i)
    ,.rm_i(rm_i)
    ,.signed_i(op_i == eFCVT_W_S)
    ,.result_o(f2i_result)
    ,.fflags_o(f2i_fflags)
  );

  logic [9:0] fclass_mask;

  fpu_int_fclass #(
    .exp_width_p(exp_width_p)
    ,.sig_width_p(sig_width_p)
  ) fclass0 (
    .a_i(rs1_i)
    ,.class_o(fclass_mask)
  );

  always_comb begin
    fflags_o = '0;
    if (is_cmp) begin
      result_o = {{(data_width_p-1){1'b0}}, cmp_bit};
      fflags_o = cmp_fflags;
    end else if (is_cvt) begin
      result_o = f2i_result;
      fflags_o = f2i_fflags;
    end else if (op_i == eFCLASS) begin
      result_o = {{(data_width_p-10){1'b0}}, fclass_mask};
    end else begin
      // FMV.X.W, raw bits
      result_o = rs1_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/fpu_int_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_int_macros.svh"

module fpu_int_stage
  import fpu_int_pkg::*;
  (
    input  logic            clk_i
    , input  logic          rst_n_i
    , input  logic          v_i
    , input  fpu_int_req_s  req_i
    , output logic          v_o
    , output fpu_int_resp_s resp_o
  );

  fpu_int_resp_s resp_n;

  fpu_int #(
    .exp_width_p(`FPU_EXP_WIDTH)
    ,.sig_width_p(`FPU_SIG_WIDTH)
    ,.data_width_p(`FPU_DATA_WIDTH)
  ) fpu_int0 (
    .op_i(req_i.op)
    ,.rm_i(req_i.rm)
    ,.rs1_i(req_i.rs1)
    ,.rs2_i(req_i.rs2)
    ,.result_o(resp_n.result)
    ,.fflags_o(resp_n.fflags)
  );

  // Valid follows the request by one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= v_i;
    end
  end

  // Holds the last response between requests
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_o <= '0;
    end else if (v_i) begin
      resp_o <= resp_n;
    end
  end

endmodule

`default_nettype wire

// File: bench/fpu_int_vectors.svh
`ifndef FPU_INT_VECTORS_SVH
`define FPU_INT_VECTORS_SVH

// Columns: name, op, rm, rs1, rs2, expected result, expected fflags
typedef struct packed {
  fpu_int_op_e op;
  frm_e        rm;
  logic [31:0] rs1;
  logic [31:0] rs2;
  logic [31:0] result;
  fflags_s     fflags;
} vector_s;

// Flag sets as {NV, DZ, OF, UF, NX}
localparam logic [4:0] nv_lp = 5'h10;
localparam logic [4:0] nx_lp = 5'h01;

string   vec_name[$];
vector_s vec_row[$];

task automatic add_vector(input string name, input fpu_int_op_e op, input frm_e rm,
                          input logic [31:0] rs1, input logic [31:0] rs2,
                          input logic [31:0] result, input logic [4:0] fflags);
  vector_s row;
  row = {op, rm, rs1, rs2, result, fflags};
  vec_name.push_back(name);
  vec_row.push_back(row);
endtask

task automatic load_table();
  // Compares, 1.0 = 3f800000 and 2.0 = 40000000
  add_vector("feq_equal", eFEQ, eRNE, 32'h3f800000, 32'h3f800000, 32'h1, 5'h00);
  add_vector("feq_unequal", eFEQ, eRNE, 32'h3f800000, 32'h40000000, 32'h0, 5'h00);
  add_vector("flt_ordered", eFLT, eRNE, 32'h3f800000, 32'h40000000, 32'h1, 5'h00);
  add_vector("flt_equal", eFLT, eRNE, 32'h40000000, 32'h40000000, 32'h0, 5'h00);
  add_vector("fle_equal", eFLE, eRNE, 32'h3f800000, 32'h3f800000, 32'h1, 5'h00);
  add_vector("fle_greater", eFLE, eRNE, 32'h40000000, 32'h3f800000, 32'h0, 5'h00);
  add_vector("flt_neg_pos", eFLT, eRNE, 32'hbf800000, 32'h3f800000, 32'h1, 5'h00);
  // Both negative, -2.0 below -1.0
  add_vector("flt_both_neg", eFLT, eRNE, 32'hc0000000, 32'hbf800000, 32'h1, 5'h00);
  add_vector("fle_both_neg", eFLE, eRNE, 32'hbf800000, 32'hc0000000, 32'h0, 5'h00);
  add_vector("feq_pzero_nzero", eFEQ, eRNE, 32'h00000000, 32'h80000000, 32'h1, 5'h00);
  add_vector("fle_pzero_nzero", eFLE, eRNE, 32'h00000000, 32'h80000000, 32'h1, 5'h00);
  add_vector("flt_pzero_nzero", eFLT, eRNE, 32'h00000000, 32'h80000000, 32'h0, 5'h00);
  add_vector("feq_qnan", eFEQ, eRNE, 32'h7fc00000, 32'h3f800000, 32'h0, 5'h00);
  add_vector("flt_qnan", eFLT, eRNE, 32'h3f800000, 32'h7fc00000, 32'h0, nv_lp);
  add_vector("fle_qnan", eFLE, eRNE, 32'h7fc00000, 32'h3f800000, 32'h0, nv_lp);
  add_vector("feq_snan", eFEQ, eRNE, 32'h7f800001, 32'h3f800000, 32'h0, nv_lp);
  // Rounding of 2.5, -2.5, 1.5, 0.3 and -0.3
  add_vector("cvt_2p5_rne", eFCVT_W_S, eRNE, 32'h40200000, 32'h0, 32'h2, nx_lp);
  add_vector("cvt_2p5_rtz", eFCVT_W_S, eRTZ, 32'h40200000, 32'h0, 32'h2, nx_lp);
  add_vector("cvt_2p5_rup", eFCVT_W_S, eRUP, 32'h40200000, 32'h0, 32'h3, nx_lp);
  add_vector("cvt_m2p5_rne", eFCVT_W_S, eRNE, 32'hc0200000, 32'h0, 32'hfffffffe, nx_lp);
  add_vector("cvt_m2p5_rtz", eFCVT_W_S, eRTZ, 32'hc0200000, 32'h0, 32'hfffffffe, nx_lp);
  add_vector("cvt_m2p5_rdn", eFCVT_W_S, eRDN, 32'hc0200000, 32'h0, 32'hfffffffd, nx_lp);
  add_vector("cvt_m2p5_rup", eFCVT_W_S, eRUP, 32'hc0200000, 32'h0, 32'hfffffffe, nx_lp);
  add_vector("cvt_m2p5_rmm", eFCVT_W_S, eRMM, 32'hc0200000, 32'h0, 32'hfffffffd, nx_lp);
  add_vector("cvt_1p5_rne", eFCVT_W_S, eRNE, 32'h3fc00000, 32'h0, 32'h2, nx_lp);
  add_vector("cvt_1p5_rtz", eFCVT_W_S, eRTZ, 32'h3fc00000, 32'h0, 32'h1, nx_lp);
  add_vector("cvt_0p3_rne", eFCVT_W_S, eRNE, 32'h3e99999a, 32'h0, 32'h0, nx_lp);
  add_vector("cvt_0p3_rup", eFCVT_W_S, eRUP, 32'h3e99999a, 32'h0, 32'h1, nx_lp);
  add_vector("cvtu_m0p3_rtz", eFCVT_WU_S, eRTZ, 32'hbe99999a, 32'h0, 32'h0, nx_lp);
  // Range edges around 2^31 and 2^32
  add_vector("cvt_2p31", eFCVT_W_S, eRNE, 32'h4f000000, 32'h0, 32'h7fffffff, nv_lp);
  add_vector("cvtu_2p31", eFCVT_WU_S, eRNE, 32'h4f000000, 32'h0, 32'h80000000, 5'h00);
  add_vector("cvt_m2p31", eFCVT_W_S, eRNE, 32'hcf000000, 32'h0, 32'h80000000, 5'h00);
  add_vector("cvtu_2p32", eFCVT_WU_S, eRNE, 32'h4f800000, 32'h0, 32'hffffffff, nv_lp);
  add_vector("cvt_m2p32", eFCVT_W_S, eRNE, 32'hcf800000, 32'h0, 32'h80000000, nv_lp);
  add_vector("cvt_pinf", eFCVT_W_S, eRNE, 32'h7f800000, 32'h0, 32'h7fffffff, nv_lp);
  add_vector("cvt_ninf", eFCVT_W_S, eRNE, 32'hff800000, 32'h0, 32'h80000000, nv_lp);
  add_vector("cvt_qnan", eFCVT_W_S, eRNE, 32'h7fc00000, 32'h0, 32'h7fffffff, nv_lp);
  add_vector("cvtu_qnan", eFCVT_WU_S, eRNE, 32'h7fc00000, 32'h0, 32'hffffffff, nv_lp);
  add_vector("cvtu_neg_one", eFCVT_WU_S, eRNE, 32'hbf800000, 32'h0, 32'h0, nv_lp);
  // One row per class bit
  add_vector("class_ninf", eFCLASS, eRNE, 32'hff800000, 32'h0, 32'h001, 5'h00);
  add_vector("class_nnorm", eFCLASS, eRNE, 32'hbf800000, 32'h0, 32'h002, 5'h00);
  add_vector("class_nsub", eFCLASS, eRNE, 32'h80000001, 32'h0, 32'h004, 5'h00);
  add_vector("class_nzero", eFCLASS, eRNE, 32'h80000000, 32'h0, 32'h008, 5'h00);
  add_vector("class_pzero", eFCLASS, eRNE, 32'h00000000, 32'h0, 32'h010, 5'h00);
  add_vector("class_psub", eFCLASS, eRNE, 32'h00000001, 32'h0, 32'h020, 5'h00);
  add_vector("class_pnorm", eFCLASS, eRNE, 32'h3f800000, 32'h0, 32'h040, 5'h00);
  add_vector("class_pinf", eFCLASS, eRNE, 32'h7f800000, 32'h0, 32'h080, 5'h00);
  add_vector("class_snan", eFCLASS, eRNE, 32'h7f800001, 32'h0, 32'h100, 5'h00);
  add_vector("class_qnan", eFCLASS, eRNE, 32'h7fc00000, 32'h0, 32'h200, 5'h00);
endtask

`endif

// File: bench/tb_fpu_int.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_int
  import fpu_int_pkg::*;
  ();

  logic          clk;
  logic          rst_n;
  logic          v_in;
  fpu_int_req_s  req;
  logic          v_out;
  fpu_int_resp_s resp;

  int          errors;
  int          checks;
  int          seed;
  int          cycles;
  logic [31:0] rand_word;

  `include "fpu_int_vectors.svh"

  fpu_int_stage uut (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.v_i(v_in)
    ,.req_i(req)
    ,.v_o(v_out)
    ,.resp_o(resp)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [36:0] expected,
                             input logic [36:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic drive_row(input int idx);
    req  = {vec_row[idx].op, vec_row[idx].rm, vec_row[idx].rs1, vec_row[idx].rs2};
    v_in = 1'b1;
  endtask

  // Called one cycle after row idx was driven
  task automatic check_response(input int idx);
    checks++;
    if (v_out !== 1'b1) begin
      $display("ERROR: no valid response for %s one cycle after its request", vec_name[idx]);
      errors++;
    end else begin
      check_value({vec_name[idx], " result"}, 37'(vec_row[idx].result), 37'(resp.result));
      check_value({vec_name[idx], " fflags"}, 37'(vec_row[idx].fflags), 37'(resp.fflags));
    end
  endtask

  initial begin
    clk    = 1'b0;
    rst_n  = 1'b0;
    v_in   = 1'b0;
    req    = '0;
    errors = 0;
    checks = 0;
    seed   = 32'h22cb_d20b;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset
    @(negedge clk);
    check_value("reset v_o", 37'(1'b0), 37'(v_out));
    check_value("reset resp_o", '0, resp);

    // Single FLT 1.0 < 2.0, response expected one edge later
    req    = {eFLT, eRNE, 32'h3f800000, 32'h40000000};
    v_in   = 1'b1;
    @(negedge clk);
    v_in   = 1'b0;
    cycles = 1;
    while (!v_out && cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    if (!v_out) begin
      $display("ERROR: timed out waiting for v_o after a single request");
      errors++;
    end else begin
      check_value("latency cycles", 37'(1), 37'(cycles));
      check_value("latency result", 37'(1), 37'(resp.result));
    end
    @(negedge clk);
    check_value("valid width", 37'(1'b0), 37'(v_out));

    // Table then a gapless FMV.X.W stream
    load_table();
    for (int i = 0; i < 64; i++) begin
      rand_word = $random(seed);
      add_vector($sformatf("fmv_stream_%0d", i), eFMV_X_W, eRNE, rand_word, 32'h0,
                 rand_word, 5'h00);
    end

    for (int i = 0; i <= vec_row.size(); i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_response(i - 1);
      end
      if (i < vec_row.size()) begin
        drive_row(i);
      end else begin
        v_in = 1'b0;
      end
    end

    @(negedge clk);
    check_value("idle after stream", 37'(1'b0), 37'(v_out));

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
+incdir+bench
hw/fpu_int_pkg.sv
hw/fpu_int_compare.sv
hw/fpu_int_f2i.sv
hw/fpu_int_fclass.sv
hw/fpu_int.sv
hw/fpu_int_stage.sv
bench/tb_fpu_int.sv

// File: Makefile
# Verilator build and run of the integer-writeback FPU testbench

VERILATOR ?= verilator
TOP       ?= tb_fpu_int
FLAGS     ?= --binary --timing -Wno-fatal
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f

SOURCES := $(wildcard hw/*.sv) $(wildcard include/*.svh) \
           $(wildcard bench/*.sv) $(wildcard bench/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
